// File: Makefile
TOP := mips_pipeline_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f mips_pipeline.f --top-module $(TOP) -o $(TOP)

run: build
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -q "TB PASSED"

lint:
	verilator --lint-only --timing -Wall -f mips_pipeline.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: mips_pipeline.f
+incdir+tb
verilog/mips_pkg.sv
verilog/mips_fetch.sv
verilog/mips_decode.sv
verilog/mips_execute.sv
verilog/mips_memory.sv
verilog/mips_pipeline.sv
tb/mips_pipeline_tb.sv

// File: tb/mips_model.svh
`ifndef MIPS_MODEL_SVH
`define MIPS_MODEL_SVH

// Program image and the state it should leave behind
word_t prog [pm_depth];
int    prog_len;
word_t exp_regs [32];
word_t model_mem [dm_depth];

function automatic word_t enc_r(input int rs, input int rt, input int rd, input logic [5:0] fn);
   return {op_rtype, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
endfunction

function automatic word_t enc_i(input logic [5:0] op, input int rs, input int rt,
                                input logic [15:0] imm);
   return {op, 5'(rs), 5'(rt), imm};
endfunction

////////////////////////////////////////////////////////////
// Random program, halt in the last slot
////////////////////////////////////////////////////////////

function automatic void gen_program(input int n);
   logic [5:0]  fns [5] = '{fn_add, fn_sub, fn_and, fn_or, fn_slt};
   int          kind;
   int          rs;
   int          rt;
   int          rd;
   int          off;
   int          wr;
   int          d1;
   int          d2;
   int          pair;
   int          last_rs;
   logic [15:0] imm;
   logic [15:0] last_imm;
   d1 = -1;
   d2 = -1;
   pair = 0;
   last_rs = 0;
   last_imm = '0;
   for (int i = 0; i < n - 1; i++)
   begin
      kind = $urandom_range(99, 0);
      // Ten registers only, so dependencies are frequent
      rs = $urandom_range(9, 0);
      rt = $urandom_range(9, 0);
      rd = $urandom_range(9, 0);
      imm = 16'($urandom);
      wr = -1;
      if (pair != 0)
      begin
         // Read back the word just stored
         prog[i] = enc_i(op_lw, last_rs, rt, last_imm);
         wr = rt;
         pair = 0;
      end
      else if (kind < 35)
      begin
         prog[i] = enc_r(rs, rt, rd, fns[$urandom_range(4, 0)]);
         wr = rd;
      end
      else if (kind < 62)
      begin
         prog[i] = enc_i(op_addi, rs, rt, imm);
         wr = rt;
      end
      else if (kind < 75)
      begin
         prog[i] = enc_i(op_lw, rs, rt, imm);
         wr = rt;
      end
      else if (kind < 88)
      begin
         prog[i] = enc_i(op_sw, rs, rt, imm);
         last_rs = rs;
         last_imm = imm;
         pair = $urandom_range(1, 0);
      end
      else
      begin
         // Compare is not forwarded, keep clear of the last two writers
         do
            rs = $urandom_range(9, 0);
         while (rs == d1 || rs == d2);
         do
            rt = $urandom_range(9, 0);
         while (rt == d1 || rt == d2);
         if ($urandom_range(1, 0) == 1)
            rt = rs;
         off = $urandom_range(3, 0);
         if (i + 1 + off > n - 1)
            off = n - 2 - i;
         prog[i] = enc_i(op_beq, rs, rt, 16'(off));
      end
      d2 = d1;
      d1 = wr;
   end
   prog[n-1] = {op_halt, 26'd0};
   prog_len = n;
endfunction

////////////////////////////////////////////////////////////
// In-order reference, one instruction per step
////////////////////////////////////////////////////////////

function automatic void run_model();
   pc_t   pc;
   pc_t   next;
   word_t instr;
   word_t a;
   word_t b;
   word_t imm;
   word_t addr;
   for (int k = 0; k < 32; k++)
      exp_regs[k] = '0;
   for (int k = 0; k < dm_depth; k++)
      model_mem[k] = '0;
   pc = '0;
   instr = prog[0];
   // Branches only go forward, so this ends at halt
   while (instr[31:26] != op_halt)
   begin
      a = exp_regs[instr[25:21]];
      b = exp_regs[instr[20:16]];
      imm = {{16{instr[15]}}, instr[15:0]};
      addr = a + imm;
      next = pc + 1;
      case (instr[31:26])
         op_rtype:
         begin
            case (instr[5:0])
               fn_add:  exp_regs[instr[15:11]] = a + b;
               fn_sub:  exp_regs[instr[15:11]] = a - b;
               fn_and:  exp_regs[instr[15:11]] = a & b;
               fn_or:   exp_regs[instr[15:11]] = a | b;
               default: exp_regs[instr[15:11]] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            endcase
         end
         op_addi: exp_regs[instr[20:16]] = addr;
         op_lw:   exp_regs[instr[20:16]] = model_mem[addr[dm_addr_w-1:0]];
         op_sw:   model_mem[addr[dm_addr_w-1:0]] = b;
         default:
         begin
            if (a == b)
               next = pc + 1 + imm;
         end
      endcase
      exp_regs[0] = '0;
      pc = next;
      instr = prog[pc[pm_addr_w-1:0]];
   end
endfunction

`endif

// File: tb/mips_pipeline_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mips_pipeline_tb;
   import mips_pkg::*;

   localparam int num_programs = 6;
   localparam int prog_size    = 40;
   localparam int hs_timeout   = 20;
   localparam int run_timeout  = 2000;

   logic                 clk;
   logic                 arst_n;
   logic                 enable;
   logic                 load_req;
   logic [pm_addr_w-1:0] load_addr;
   word_t                load_data;
   logic                 rd_req;
   reg_idx_t             rd_addr;
   logic                 load_ack;
   word_t                rd_data;
   logic                 rd_ack;
   logic                 finished;

   `include "mips_model.svh"

   mips_pipeline mips_pipeline_inst (
      .clk       (clk),
      .arst_n    (arst_n),
      .enable    (enable),
      .load_req  (load_req),
      .load_addr (load_addr),
      .load_data (load_data),
      .rd_req    (rd_req),
      .rd_addr   (rd_addr),
      .load_ack  (load_ack),
      .rd_data   (rd_data),
      .rd_ack    (rd_ack),
      .finished  (finished)
   );

   always #2 clk = ~clk;

   ////////////////////////////////////////////////////////////
   // Reporting
   ////////////////////////////////////////////////////////////

   task automatic fail_run(input string what);
      $display("%s", what);
      $display("TB FAILED");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_value(input string name, input word_t expected, input word_t actual);
      if (actual !== expected)
         fail_run($sformatf("[ERROR] %0t ns %s expected %h actual %h",
                            $time, name, expected, actual));
   endtask

   task automatic apply_reset();
      @(posedge clk);
      arst_n   <= 1'b0;
      enable   <= 1'b0;
      load_req <= 1'b0;
      rd_req   <= 1'b0;
      repeat (5) @(posedge clk);
      arst_n <= 1'b1;
   endtask

   ////////////////////////////////////////////////////////////
   // Four-phase hosts
   ////////////////////////////////////////////////////////////

   task automatic load_word(input int addr, input word_t data);
      int n;
      @(posedge clk);
      load_req  <= 1'b1;
      load_addr <= addr[pm_addr_w-1:0];
      load_data <= data;
      // Ack is one cycle behind req
      @(negedge clk);
      check_value("load_ack", '0, word_t'(load_ack));
      n = 0;
      while (!load_ack && n < hs_timeout)
      begin
         @(negedge clk);
         n++;
      end
      if (!load_ack)
         fail_run("load_ack never rose after load_req");
      @(posedge clk);
      load_req <= 1'b0;
      @(negedge clk);
      check_value("load_ack", 32'd1, word_t'(load_ack));
      n = 0;
      while (load_ack && n < hs_timeout)
      begin
         @(negedge clk);
         n++;
      end
      if (load_ack)
         fail_run("load_ack never fell after load_req dropped");
   endtask

   task automatic read_back(input int idx, output word_t data);
      int n;
      @(posedge clk);
      rd_req  <= 1'b1;
      rd_addr <= idx[reg_addr_w-1:0];
      @(negedge clk);
      check_value("rd_ack", '0, word_t'(rd_ack));
      n = 0;
      while (!rd_ack && n < hs_timeout)
      begin
         @(negedge clk);
         n++;
      end
      if (!rd_ack)
         fail_run("rd_ack never rose after rd_req");
      data = rd_data;
      @(posedge clk);
      rd_req <= 1'b0;
      n = 0;
      @(negedge clk);
      while (rd_ack && n < hs_timeout)
      begin
         @(negedge clk);
         n++;
      end
      if (rd_ack)
         fail_run("rd_ack never fell after rd_req dropped");
   endtask

   ////////////////////////////////////////////////////////////
   // One program from reset to register compare
   ////////////////////////////////////////////////////////////

   task automatic run_program(input int index);
      int    n;
      word_t data;
      gen_program(prog_size);
      run_model();
      apply_reset();
      // Nothing moves before the first request
      @(negedge clk);
      check_value("load_ack", '0, word_t'(load_ack));
      check_value("rd_ack", '0, word_t'(rd_ack));
      check_value("finished", '0, word_t'(finished));
      for (int a = 0; a < prog_len; a++)
         load_word(a, prog[a]);
      @(posedge clk);
      enable <= 1'b1;
      n = 0;
      @(negedge clk);
      while (!finished && n < run_timeout)
      begin
         @(negedge clk);
         n++;
      end
      if (!finished)
         fail_run($sformatf("program %0d never raised finished", index));
      // Sticky flag
      repeat (4)
      begin
         @(negedge clk);
         check_value("finished", 32'd1, word_t'(finished));
      end
      @(posedge clk);
      enable <= 1'b0;
      for (int r = 0; r < 32; r++)
      begin
         read_back(r, data);
         check_value($sformatf("rd_data r%0d", r), exp_regs[r], data);
      end
      check_value("finished", 32'd1, word_t'(finished));
      $display("program %0d done after %0d cycles", index, n);
   endtask

   initial
   begin
      clk       = 1'b0;
      arst_n    = 1'b0;
      enable    = 1'b0;
      load_req  = 1'b0;
      load_addr = '0;
      load_data = '0;
      rd_req    = 1'b0;
      rd_addr   = '0;
      void'($urandom(32'hf1a1_6df3));
      for (int p = 0; p < num_programs; p++)
         run_program(p);
      $display("TB PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// File: verilog/mips_decode.sv
`timescale 1ns/1ps
`default_nettype none

module mips_decode (
   input  wire                       clk,
   input  wire                       arst_n,
   input  wire                       enable,
   input  wire mips_pkg::if_id_t     if_id,
   input  wire mips_pkg::wb_t        wb,
   input  wire                       rd_req,
   input  wire mips_pkg::reg_idx_t   rd_addr,
   output mips_pkg::redirect_t       redirect,
   output mips_pkg::id_ex_t          id_ex,
   output mips_pkg::word_t           rd_data,
   output logic                      rd_ack
);
   import mips_pkg::*;

   word_t      regs [2**reg_addr_w];
   logic [5:0] opcode;
   logic [5:0] funct;
   reg_idx_t   rs;
   reg_idx_t   rt;
   reg_idx_t   rd;
   word_t      rs_val;
   word_t      rt_val;
   word_t      imm;
   ctrl_t      ctrl;
   logic       load_use;
   logic       is_beq;

   assign opcode = if_id.instr[31:26];
   assign funct  = if_id.instr[5:0];
   assign rs     = if_id.instr[25:21];
   assign rt     = if_id.instr[20:16];
   assign rd     = if_id.instr[15:11];
   assign imm    = {{(xlen-16){if_id.instr[15]}}, if_id.instr[15:0]};

   // Write-through read, r0 hardwired
   function automatic word_t read_reg(input reg_idx_t idx);
      word_t val;
      val = regs[idx];
      if (idx == '0)
         val = '0;
      else if (wb.reg_write && wb.dest == idx)
         val = wb.data;
      return val;
   endfunction

   always_comb
   begin
      rs_val = read_reg(rs);
      rt_val = read_reg(rt);
   end

   ////////////////////////////////////////////////////////////
   // Control decode
   ////////////////////////////////////////////////////////////

   always_comb
   begin
      ctrl = '0;
      if (if_id.valid)
      begin
         case (opcode)
            op_rtype:
            begin
               ctrl.reg_write = 1'b1;
               ctrl.reg_dst   = 1'b1;
               case (funct)
                  fn_add:  ctrl.alu_op = alu_add;
                  fn_sub:  ctrl.alu_op = alu_sub;
                  fn_and:  ctrl.alu_op = alu_and;
                  fn_or:   ctrl.alu_op = alu_or;
                  fn_slt:  ctrl.alu_op = alu_slt;
                  // unknown funct becomes a bubble
                  default: ctrl.reg_write = 1'b0;
               endcase
            end
            op_addi:
            begin
               ctrl.reg_write = 1'b1;
               ctrl.alu_src   = 1'b1;
            end
            op_lw:
            begin
               ctrl.reg_write  = 1'b1;
               ctrl.mem_to_reg = 1'b1;
               ctrl.mem_read   = 1'b1;
               ctrl.alu_src    = 1'b1;
            end
            op_sw:
            begin
               ctrl.mem_write = 1'b1;
               ctrl.alu_src   = 1'b1;
            end
            op_halt: ctrl.halt = 1'b1;
            default: ctrl = '0;
         endcase
      end
   end

   // Load in EX feeding this instruction
   assign load_use = if_id.valid && id_ex.ctrl.mem_read && (id_ex.rt != '0) &&
                     (id_ex.rt == rs || id_ex.rt == rt);
   assign is_beq   = if_id.valid && (opcode == op_beq);

   // Target relative to the word after the branch
   always_comb
   begin
      redirect.stall  = load_use;
      redirect.taken  = is_beq && !load_use && (rs_val == rt_val);
      redirect.target = if_id.pc + 1 + imm;
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         id_ex <= '0;
      else if (enable)
      begin
         if (load_use)
            id_ex <= '0;
         else
            id_ex <= '{ctrl: ctrl, rs_val: rs_val, rt_val: rt_val, imm: imm,
                       rs: rs, rt: rt, rd: rd};
      end
   end

   ////////////////////////////////////////////////////////////
   // Register file and read-back port
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         for (int i = 0; i < 2**reg_addr_w; i++)
            regs[i] <= '0;
      end
      else if (enable && wb.reg_write && wb.dest != '0)
         regs[wb.dest] <= wb.data;
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         rd_ack <= 1'b0;
      else if (rd_req && !rd_ack)
         rd_ack <= 1'b1;
      else if (!rd_req && rd_ack)
         rd_ack <= 1'b0;
   end

   // Captured as ack rises, held until the next request
   always_ff @(posedge clk)
   begin
      if (rd_req && !rd_ack)
         rd_data <= regs[rd_addr];
   end

   ap_rd_ack_after_req: assert property (@(posedge clk) disable iff (!arst_n)
      $rose(rd_ack) |-> $past(rd_req));

   // The bubble behind a stall cannot be a load
   ap_stall_once: assert property (@(posedge clk) disable iff (!arst_n)
      (enable && redirect.stall) |=> !redirect.stall);

endmodule

`default_nettype wire

// File: verilog/mips_execute.sv
`timescale 1ns/1ps
`default_nettype none

module mips_execute (
   input  wire                     clk,
   input  wire                     arst_n,
   input  wire                     enable,
   input  wire mips_pkg::id_ex_t   id_ex,
   input  wire mips_pkg::wb_t      wb,
   output mips_pkg::ex_mem_t       ex_mem
);
   import mips_pkg::*;

   word_t    op_a;
   word_t    fwd_b;
   word_t    op_b;
   word_t    alu_result;
   reg_idx_t dest;

   ////////////////////////////////////////////////////////////
   // Forwarding
   ////////////////////////////////////////////////////////////

   // EX/MEM is younger, so it overrides writeback
   function automatic word_t forward(input reg_idx_t src, input word_t reg_val);
      word_t val;
      val = reg_val;
      if (wb.reg_write && wb.dest != '0 && wb.dest == src)
         val = wb.data;
      if (ex_mem.ctrl.reg_write && ex_mem.dest != '0 && ex_mem.dest == src)
         val = ex_mem.alu_result;
      return val;
   endfunction

   always_comb
   begin
      op_a  = forward(id_ex.rs, id_ex.rs_val);
      fwd_b = forward(id_ex.rt, id_ex.rt_val);
   end

   assign op_b = id_ex.ctrl.alu_src ? id_ex.imm : fwd_b;

   ////////////////////////////////////////////////////////////
   // ALU
   ////////////////////////////////////////////////////////////

   always_comb
   begin
      case (id_ex.ctrl.alu_op)
         alu_add: alu_result = op_a + op_b;
         alu_sub: alu_result = op_a - op_b;
         alu_and: alu_result = op_a & op_b;
         alu_or:  alu_result = op_a | op_b;
         // signed compare
         alu_slt: alu_result = ($signed(op_a) < $signed(op_b)) ? word_t'(1) : '0;
         default: alu_result = '0;
      endcase
   end

   // R-type writes rd, I-type writes rt
   assign dest = id_ex.ctrl.reg_dst ? id_ex.rd : id_ex.rt;

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         ex_mem <= '0;
      else if (enable)
         ex_mem <= '{ctrl: id_ex.ctrl, alu_result: alu_result, store_data: fwd_b,
                     dest: dest};
   end

endmodule

`default_nettype wire

// File: verilog/mips_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module mips_fetch (
   input  wire                            clk,
   input  wire                            arst_n,
   input  wire                            enable,
   input  wire                            load_req,
   input  wire [mips_pkg::pm_addr_w-1:0]  load_addr,
   input  wire mips_pkg::word_t           load_data,
   input  wire mips_pkg::redirect_t       redirect,
   output logic                           load_ack,
   output mips_pkg::if_id_t               if_id
);
   import mips_pkg::*;

   pc_t   pc;
   pc_t   pc_next;
   word_t pm [pm_depth];
   word_t instr;
   logic  fetch_halt;

   assign instr      = pm[pc[pm_addr_w-1:0]];
   assign fetch_halt = (instr[31:26] == op_halt);

   ////////////////////////////////////////////////////////////
   // Next PC
   ////////////////////////////////////////////////////////////

   // Branch wins over halt freeze and stall
   always_comb
   begin
      if (redirect.taken)
         pc_next = redirect.target;
      else if (redirect.stall || fetch_halt)
         pc_next = pc;
      else
         pc_next = pc + 1;
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         pc <= '0;
      else if (enable)
         pc <= pc_next;
   end

   ////////////////////////////////////////////////////////////
   // Program load, four-phase
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         load_ack <= 1'b0;
      else if (load_req && !load_ack)
         load_ack <= 1'b1;
      else if (!load_req && load_ack)
         load_ack <= 1'b0;
   end

   // One write per request
   always_ff @(posedge clk)
   begin
      if (load_req && !load_ack)
         pm[load_addr] <= load_data;
   end

   // IF/ID, flushed by a taken beq and held on a stall
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         if_id <= '0;
      else if (enable)
      begin
         if (redirect.taken)
            if_id <= '0;
         else if (!redirect.stall)
            if_id <= '{valid: 1'b1, pc: pc, instr: instr};
      end
   end

   // Host only loads while the core is idle
   ap_load_idle: assert property (@(posedge clk) disable iff (!arst_n)
      $rose(load_req) |-> !enable);

endmodule

`default_nettype wire

// File: verilog/mips_memory.sv
`timescale 1ns/1ps
`default_nettype none

module mips_memory (
   input  wire                     clk,
   input  wire                     arst_n,
   input  wire                     enable,
   input  wire mips_pkg::ex_mem_t  ex_mem,
   output mips_pkg::wb_t           wb,
   output logic                    finished
);
   import mips_pkg::*;

   word_t                dmem [dm_depth];
   logic [dm_addr_w-1:0] dm_addr;
   word_t                load_data;

   // Word index from the low bits of the address
   assign dm_addr   = ex_mem.alu_result[dm_addr_w-1:0];
   assign load_data = dmem[dm_addr];

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         for (int i = 0; i < dm_depth; i++)
            dmem[i] <= '0;
      end
      else if (enable && ex_mem.ctrl.mem_write)
         dmem[dm_addr] <= ex_mem.store_data;
   end

   ////////////////////////////////////////////////////////////
   // MEM/WB and completion
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         wb <= '0;
      else if (enable)
         wb <= '{reg_write: ex_mem.ctrl.reg_write, dest: ex_mem.dest,
                 data: ex_mem.ctrl.mem_to_reg ? load_data : ex_mem.alu_result,
                 halt: ex_mem.ctrl.halt};
   end

   // Sticky once the halt bubble retires
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         finished <= 1'b0;
      else if (enable && wb.halt)
         finished <= 1'b1;
   end

   ap_dm_addr_known: assert property (@(posedge clk) disable iff (!arst_n)
      (enable && (ex_mem.ctrl.mem_read || ex_mem.ctrl.mem_write))
      |-> !$isunknown(ex_mem.alu_result[dm_addr_w-1:0]));

endmodule

`default_nettype wire

// File: verilog/mips_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

module mips_pipeline (
   input  wire                            clk,
   input  wire                            arst_n,
   input  wire                            enable,
   input  wire                            load_req,
   input  wire [mips_pkg::pm_addr_w-1:0]  load_addr,
   input  wire mips_pkg::word_t           load_data,
   input  wire                            rd_req,
   input  wire mips_pkg::reg_idx_t        rd_addr,
   output logic                           load_ack,
   output mips_pkg::word_t                rd_data,
   output logic                           rd_ack,
   output logic                           finished
);
   import mips_pkg::*;

   // Stage to stage records
   if_id_t    if_id;
   redirect_t redirect;
   id_ex_t    id_ex;
   ex_mem_t   ex_mem;
   wb_t       wb;

   mips_fetch mips_fetch_inst (
      .clk       (clk),
      .arst_n    (arst_n),
      .enable    (enable),
      .load_req  (load_req),
      .load_addr (load_addr),
      .load_data (load_data),
      .redirect  (redirect),
      .load_ack  (load_ack),
      .if_id     (if_id)
   );

   mips_decode mips_decode_inst (
      .clk      (clk),
      .arst_n   (arst_n),
      .enable   (enable),
      .if_id    (if_id),
      .wb       (wb),
      .rd_req   (rd_req),
      .rd_addr  (rd_addr),
      .redirect (redirect),
      .id_ex    (id_ex),
      .rd_data  (rd_data),
      .rd_ack   (rd_ack)
   );

   mips_execute mips_execute_inst (
      .clk    (clk),
      .arst_n (arst_n),
      .enable (enable),
      .id_ex  (id_ex),
      .wb     (wb),
      .ex_mem (ex_mem)
   );

   mips_memory mips_memory_inst (
      .clk      (clk),
      .arst_n   (arst_n),
      .enable   (enable),
      .ex_mem   (ex_mem),
      .wb       (wb),
      .finished (finished)
   );

endmodule

`default_nettype wire

// File: verilog/mips_pkg.sv
`default_nettype none

package mips_pkg;

   ////////////////////////////////////////////////////////////
   // Widths and memory sizes
   ////////////////////////////////////////////////////////////

   localparam int xlen       = 32;
   localparam int reg_addr_w = 5;

   // Both memories are word addressed
   localparam int pm_depth  = 64;
   localparam int pm_addr_w = 6;
   localparam int dm_depth  = 64;
   localparam int dm_addr_w = 6;

   // Primary opcodes, instr[31:26]
   localparam logic [5:0] op_rtype = 6'd0;
   localparam logic [5:0] op_addi  = 6'd8;
   localparam logic [5:0] op_lw    = 6'd35;
   localparam logic [5:0] op_sw    = 6'd43;
   localparam logic [5:0] op_beq   = 6'd4;
   localparam logic [5:0] op_halt  = 6'd21;

   // R-type function codes, instr[5:0]
   localparam logic [5:0] fn_add = 6'd32;
   localparam logic [5:0] fn_sub = 6'd34;
   localparam logic [5:0] fn_and = 6'd36;
   localparam logic [5:0] fn_or  = 6'd37;
   localparam logic [5:0] fn_slt = 6'd42;

   typedef logic [xlen-1:0]       word_t;
   typedef logic [xlen-1:0]       pc_t;
   typedef logic [reg_addr_w-1:0] reg_idx_t;

   typedef enum logic [2:0] {
      alu_add,
      alu_sub,
      alu_and,
      alu_or,
      alu_slt
   } alu_op_t;

   ////////////////////////////////////////////////////////////
   // Stage records
   ////////////////////////////////////////////////////////////

   typedef struct packed {
      logic    reg_write;
      logic    mem_to_reg;
      logic    mem_read;
      logic    mem_write;
      logic    alu_src;
      logic    reg_dst;
      alu_op_t alu_op;
      logic    halt;
   } ctrl_t;

   typedef struct packed {
      logic  valid;
      pc_t   pc;
      word_t instr;
   } if_id_t;

   // Decode back to fetch
   typedef struct packed {
      logic stall;
      logic taken;
      pc_t  target;
   } redirect_t;

   typedef struct packed {
      ctrl_t    ctrl;
      word_t    rs_val;
      word_t    rt_val;
      word_t    imm;
      reg_idx_t rs;
      reg_idx_t rt;
      reg_idx_t rd;
   } id_ex_t;

   typedef struct packed {
      ctrl_t    ctrl;
      word_t    alu_result;
      word_t    store_data;
      reg_idx_t dest;
   } ex_mem_t;

   // Register write from the last stage
   typedef struct packed {
      logic     reg_write;
      reg_idx_t dest;
      word_t    data;
      logic     halt;
   } wb_t;

endpackage

`default_nettype wire
